/* verilog/vm_pkg.sv */
package vm_pkg;

  localparam int PRODUCT_W    = 4;
  localparam int NUM_PRODUCTS = 10;   // Codes 1 to 10 with 0 for none
  localparam int MONEY_W      = 21;
  localparam int NOTE_W       = 16;
  localparam int NUM_DENOMS   = 15;

  // Largest note first
  localparam logic [NOTE_W-1:0] DENOM_VALUES [NUM_DENOMS] = '{
    16'd50000,
    16'd20000,
    16'd10000,
    16'd5000,
    16'd2000,
    16'd1000,
    16'd500,
    16'd200,
    16'd100,
    16'd50,
    16'd25,
    16'd10,
    16'd5,
    16'd2,
    16'd1
  };

  // Indexed by product code minus one
  localparam logic [NOTE_W-1:0] PRICES [NUM_PRODUCTS] = '{
    16'd100,
    16'd150,
    16'd120,
    16'd200,
    16'd180,
    16'd175,
    16'd80,
    16'd210,
    16'd130,
    16'd50
  };

  typedef enum logic [2:0] {
    IDLE,
    SELECT,
    PAY,
    SETTLE,
    DISPENSE,
    NO_CHANGE,
    SOLD_OUT
  } vm_state_t;

endpackage

/* verilog/product_store.sv */
`timescale 1ns/1ps

module product_store #(
  parameter int STOCK_INIT = 10
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [vm_pkg::PRODUCT_W-1:0] i_product,
  input  logic                         i_take,
  output logic                         o_available,
  output logic [vm_pkg::NOTE_W-1:0]    o_price,
  output logic                         o_sold_out
);

  localparam int STOCK_W = (STOCK_INIT > 0) ? $clog2(STOCK_INIT + 1) : 1;

  logic [STOCK_W-1:0]           stock [vm_pkg::NUM_PRODUCTS];
  logic                         sel_valid;
  logic [vm_pkg::PRODUCT_W-1:0] sel_idx;
  logic                         any_left;

  assign sel_valid = (i_product != '0) && (i_product <= vm_pkg::NUM_PRODUCTS);
  assign sel_idx   = sel_valid ? (i_product - 1'b1) : '0;

  assign o_available = sel_valid && (stock[sel_idx] != '0);
  assign o_price     = sel_valid ? vm_pkg::PRICES[sel_idx] : '0;

  always_comb begin
    any_left = 1'b0;
    for (int p = 0; p < vm_pkg::NUM_PRODUCTS; p++) begin
      any_left = any_left | (stock[p] != '0);
    end
  end

  assign o_sold_out = !any_left;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int p = 0; p < vm_pkg::NUM_PRODUCTS; p++) begin
        stock[p] <= STOCK_W'(STOCK_INIT);
      end
    end else if (i_take) begin
      stock[sel_idx] <= stock[sel_idx] - 1'b1;   // Availability checked upstream
    end
  end

endmodule

/* verilog/change_picker.sv */
`timescale 1ns/1ps

module change_picker (
  input  logic [vm_pkg::MONEY_W-1:0]    i_remaining,
  input  logic [vm_pkg::NUM_DENOMS-1:0] i_in_stock,
  output logic                          o_pick_valid,
  output logic [3:0]                    o_pick_index,
  output logic [vm_pkg::MONEY_W-1:0]    o_pick_value
);

  localparam int PAD_W = vm_pkg::MONEY_W - vm_pkg::NOTE_W;

  // Scan from the smallest note up, so the last hit is the largest that fits
  always_comb begin
    o_pick_valid = 1'b0;
    o_pick_index = '0;
    for (int d = vm_pkg::NUM_DENOMS - 1; d >= 0; d--) begin
      if (i_in_stock[d] && ({{PAD_W{1'b0}}, vm_pkg::DENOM_VALUES[d]} <= i_remaining)) begin
        o_pick_valid = 1'b1;
        o_pick_index = 4'(d);
      end
    end
  end

  assign o_pick_value = o_pick_valid ?
                        {{PAD_W{1'b0}}, vm_pkg::DENOM_VALUES[o_pick_index]} : '0;

endmodule

/* verilog/cash_box.sv */
`timescale 1ns/1ps

module cash_box #(
  parameter int NOTE_INIT  = 10,
  parameter int NOTE_CNT_W = 8
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [vm_pkg::NOTE_W-1:0]  i_money,
  input  logic                       i_accept,
  input  logic                       i_pay,
  input  logic [vm_pkg::MONEY_W-1:0] i_remaining,
  output logic                       o_note_valid,
  output logic                       o_pick_valid,
  output logic [vm_pkg::MONEY_W-1:0] o_pick_value
);

  logic [NOTE_CNT_W-1:0]         notes [vm_pkg::NUM_DENOMS];
  logic [vm_pkg::NUM_DENOMS-1:0] match_hot;   // One-hot match of i_money against the table
  logic [vm_pkg::NUM_DENOMS-1:0] in_stock;
  logic [3:0]                    pick_index;

  always_comb begin
    for (int d = 0; d < vm_pkg::NUM_DENOMS; d++) begin
      match_hot[d] = (i_money == vm_pkg::DENOM_VALUES[d]);
      in_stock[d]  = (notes[d] != '0);
    end
  end

  assign o_note_valid = |match_hot;

  change_picker u_picker (
    .i_remaining  (i_remaining),
    .i_in_stock   (in_stock),
    .o_pick_valid (o_pick_valid),
    .o_pick_index (pick_index),
    .o_pick_value (o_pick_value)
  );

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int d = 0; d < vm_pkg::NUM_DENOMS; d++) begin
        notes[d] <= NOTE_CNT_W'(NOTE_INIT);
      end
    end else begin
      for (int d = 0; d < vm_pkg::NUM_DENOMS; d++) begin
        if (i_accept && match_hot[d]) begin
          if (notes[d] != '1) notes[d] <= notes[d] + 1'b1;   // Saturate
        end else if (i_pay && (pick_index == 4'(d))) begin
          notes[d] <= notes[d] - 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/vm_controller.sv */
`timescale 1ns/1ps

module vm_controller (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_buy,
  input  logic [vm_pkg::PRODUCT_W-1:0] i_product,
  input  logic [vm_pkg::NOTE_W-1:0]    i_money,
  output logic [vm_pkg::PRODUCT_W-1:0] o_product,
  output logic [vm_pkg::MONEY_W-1:0]   o_change,
  output logic [vm_pkg::MONEY_W-1:0]   o_change_total,
  output logic                         o_busy,
  output logic                         o_no_change,
  output logic                         o_strobe,
  output logic                         o_need_more_money,
  output logic                         o_empty,
  input  logic                         i_available,
  input  logic [vm_pkg::NOTE_W-1:0]    i_price,
  input  logic                         i_sold_out,
  output logic                         o_take,
  input  logic                         i_note_valid,
  output logic                         o_accept,
  input  logic                         i_pick_valid,
  input  logic [vm_pkg::MONEY_W-1:0]   i_pick_value,
  output logic                         o_pay,
  output logic [vm_pkg::MONEY_W-1:0]   o_remaining
);

  localparam int PAD_W = vm_pkg::MONEY_W - vm_pkg::NOTE_W;

  vm_pkg::vm_state_t state, state_nxt;

  logic [vm_pkg::NOTE_W-1:0]  price;
  logic [vm_pkg::MONEY_W-1:0] amount;       // Paid sum and later the change still owed
  logic [vm_pkg::MONEY_W-1:0] price_ext;
  logic [vm_pkg::MONEY_W-1:0] note_amount;
  logic [vm_pkg::MONEY_W-1:0] paid_sum;
  logic [vm_pkg::MONEY_W-1:0] owed;
  logic [vm_pkg::MONEY_W-1:0] left_after;
  logic                       price_reached;

  assign price_ext     = {{PAD_W{1'b0}}, price};
  assign note_amount   = i_note_valid ? {{PAD_W{1'b0}}, i_money} : '0;  // Odd values dropped
  assign paid_sum      = amount + note_amount;
  assign price_reached = (paid_sum >= price_ext);
  assign owed          = amount - price_ext;
  assign left_after    = amount - i_pick_value;

  assign o_take   = (state == vm_pkg::SELECT) && i_available;
  assign o_accept = (state == vm_pkg::PAY);
  assign o_pay    = (state == vm_pkg::DISPENSE) && i_pick_valid;

  assign o_remaining       = amount;
  assign o_need_more_money = (state == vm_pkg::PAY) && !price_reached;
  assign o_empty           = (state == vm_pkg::SOLD_OUT);
  assign o_busy            = (state != vm_pkg::IDLE) && (state != vm_pkg::SOLD_OUT);

  always_comb begin
    state_nxt = state;
    case (state)
      vm_pkg::IDLE: begin
        if (i_sold_out) state_nxt = vm_pkg::SOLD_OUT;
        else if (i_buy) state_nxt = vm_pkg::SELECT;
      end
      vm_pkg::SELECT: if (i_available) state_nxt = vm_pkg::PAY;
      vm_pkg::PAY: if (price_reached) state_nxt = vm_pkg::SETTLE;
      vm_pkg::SETTLE: state_nxt = vm_pkg::DISPENSE;
      vm_pkg::DISPENSE: begin
        if ((amount == '0) || (i_pick_valid && (left_after == '0))) begin
          state_nxt = vm_pkg::IDLE;
        end else if (!i_pick_valid) begin
          state_nxt = vm_pkg::NO_CHANGE;   // Cash box ran dry
        end
      end
      vm_pkg::NO_CHANGE: state_nxt = vm_pkg::IDLE;
      vm_pkg::SOLD_OUT: state_nxt = vm_pkg::SOLD_OUT;   // Held until reset
      default: state_nxt = vm_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state          <= vm_pkg::IDLE;
      o_product      <= '0;
      o_change       <= '0;
      o_change_total <= '0;
      o_strobe       <= 1'b0;
      o_no_change    <= 1'b0;
    end else begin
      state       <= state_nxt;
      o_change    <= '0;
      o_strobe    <= 1'b0;
      o_no_change <= 1'b0;
      case (state)
        vm_pkg::SELECT: if (i_available) o_product <= i_product;
        vm_pkg::SETTLE: o_change_total <= owed;
        vm_pkg::DISPENSE: begin
          if (amount == '0) begin
            o_strobe <= 1'b1;   // Exact payment
          end else if (i_pick_valid) begin
            o_change <= i_pick_value;
            o_strobe <= (left_after == '0);
          end
        end
        vm_pkg::NO_CHANGE: begin
          o_strobe    <= 1'b1;
          o_no_change <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Transaction data
  always_ff @(posedge i_clk) begin
    case (state)
      vm_pkg::SELECT: begin
        if (i_available) begin
          price  <= i_price;
          amount <= '0;
        end
      end
      vm_pkg::PAY: amount <= paid_sum;
      vm_pkg::SETTLE: amount <= owed;
      vm_pkg::DISPENSE: if (i_pick_valid) amount <= left_after;
      default: ;
    endcase
  end

endmodule

/* verilog/vending_machine.sv */
`timescale 1ns/1ps

module vending_machine #(
  parameter int STOCK_INIT = 10,
  parameter int NOTE_INIT  = 10,
  parameter int NOTE_CNT_W = 8
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_buy,
  input  logic [vm_pkg::PRODUCT_W-1:0] i_product,
  input  logic [vm_pkg::NOTE_W-1:0]    i_money,
  output logic [vm_pkg::PRODUCT_W-1:0] o_product,
  output logic [vm_pkg::MONEY_W-1:0]   o_change,
  output logic [vm_pkg::MONEY_W-1:0]   o_change_total,
  output logic                         o_busy,
  output logic                         o_no_change,
  output logic                         o_strobe,
  output logic                         o_need_more_money,
  output logic                         o_empty
);

  logic                       take;
  logic                       available;
  logic [vm_pkg::NOTE_W-1:0]  price;
  logic                       sold_out;
  logic                       note_valid;
  logic                       accept;
  logic                       pay;
  logic                       pick_valid;
  logic [vm_pkg::MONEY_W-1:0] pick_value;
  logic [vm_pkg::MONEY_W-1:0] remaining;

  vm_controller u_ctrl (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_buy             (i_buy),
    .i_product         (i_product),
    .i_money           (i_money),
    .o_product         (o_product),
    .o_change          (o_change),
    .o_change_total    (o_change_total),
    .o_busy            (o_busy),
    .o_no_change       (o_no_change),
    .o_strobe          (o_strobe),
    .o_need_more_money (o_need_more_money),
    .o_empty           (o_empty),
    .i_available       (available),
    .i_price           (price),
    .i_sold_out        (sold_out),
    .o_take            (take),
    .i_note_valid      (note_valid),
    .o_accept          (accept),
    .i_pick_valid      (pick_valid),
    .i_pick_value      (pick_value),
    .o_pay             (pay),
    .o_remaining       (remaining)
  );

  // Store sees the live code so the stock check happens during selection
  product_store #(
    .STOCK_INIT (STOCK_INIT)
  ) u_store (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_product   (i_product),
    .i_take      (take),
    .o_available (available),
    .o_price     (price),
    .o_sold_out  (sold_out)
  );

  cash_box #(
    .NOTE_INIT  (NOTE_INIT),
    .NOTE_CNT_W (NOTE_CNT_W)
  ) u_cash (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_money      (i_money),
    .i_accept     (accept),
    .i_pay        (pay),
    .i_remaining  (remaining),
    .o_note_valid (note_valid),
    .o_pick_valid (pick_valid),
    .o_pick_value (pick_value)
  );

endmodule

/* testbench/tb_vending_machine.sv */
`timescale 1ns/1ps

module tb_vending_machine;

  localparam int CLK_PERIOD = 100;
  localparam int MAX_LINES  = 64;

  logic                         i_clk = 1'b0;
  logic                         i_rst_n;
  logic                         i_buy;
  logic [vm_pkg::PRODUCT_W-1:0] i_product;
  logic [vm_pkg::NOTE_W-1:0]    i_money;
  logic [vm_pkg::PRODUCT_W-1:0] o_product;
  logic [vm_pkg::MONEY_W-1:0]   o_change;
  logic [vm_pkg::MONEY_W-1:0]   o_change_total;
  logic                         o_busy;
  logic                         o_no_change;
  logic                         o_strobe;
  logic                         o_need_more_money;
  logic                         o_empty;

  // One entry per transaction line
  int     t_code  [MAX_LINES];
  int     t_sold  [MAX_LINES];
  int     t_count [MAX_LINES];
  int     t_notes [MAX_LINES][4];
  int     t_total [MAX_LINES];
  int     t_nc    [MAX_LINES];
  int     num_lines = 0;
  int     errors    = 0;
  int     checks    = 0;
  integer seed      = 54604;
  bit     loaded    = 1'b0;

  vending_machine #(
    .STOCK_INIT (2),
    .NOTE_INIT  (1)
  ) i_dut (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_buy             (i_buy),
    .i_product         (i_product),
    .i_money           (i_money),
    .o_product         (o_product),
    .o_change          (o_change),
    .o_change_total    (o_change_total),
    .o_busy            (o_busy),
    .o_no_change       (o_no_change),
    .o_strobe          (o_strobe),
    .o_need_more_money (o_need_more_money),
    .o_empty           (o_empty)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  function automatic bit is_denom(input int value);
    case (value)
      1, 2, 5, 10, 25, 50, 100, 200, 500: return 1'b1;
      1000, 2000, 5000, 10000, 20000, 50000: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic load_lines();
    int               fd;
    int               r;
    int               code;
    int               sold;
    int               cnt;
    int               m0;
    int               m1;
    int               m2;
    int               m3;
    int               total;
    int               nc;
    logic [8*160-1:0] skip_text;
    fd = $fopen("testbench/vm_input.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/vm_input.txt");
      return;
    end
    while (!$feof(fd) && (num_lines < MAX_LINES)) begin
      r = $fscanf(fd, "%d", code);
      if (r == 1) begin
        r = $fscanf(fd, "%d %d %d %d %d %d %d %d", sold, cnt, m0, m1, m2, m3, total, nc);
        if (r == 8) begin
          t_code[num_lines]     = code;
          t_sold[num_lines]     = sold;
          t_count[num_lines]    = cnt;
          t_notes[num_lines][0] = m0;
          t_notes[num_lines][1] = m1;
          t_notes[num_lines][2] = m2;
          t_notes[num_lines][3] = m3;
          t_total[num_lines]    = total;
          t_nc[num_lines]       = nc;
          num_lines++;
        end else begin
          $display("transaction %0d in the input file is incomplete", num_lines);
          errors++;
        end
      end else if (r == 0) begin
        r = $fgets(skip_text, fd);   // Comment line
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input int idx);
    int price;
    int sum;
    int paid_out;
    int last;
    int waited;
    bit done;
    price    = -t_total[idx];
    sum      = 0;
    paid_out = 0;
    last     = 32'h7fff_ffff;
    done     = 1'b0;
    for (int k = 0; k < t_count[idx]; k++) begin
      if (is_denom(t_notes[idx][k])) price += t_notes[idx][k];
    end
    @(negedge i_clk);
    i_buy     = !o_busy;   // FSM may still sit in SELECT after a refused code
    i_product = t_code[idx];
    @(negedge i_clk);
    i_buy = 1'b0;
    if (t_sold[idx] != 0) begin
      repeat (3) @(negedge i_clk);
      check_value("o_busy", o_busy, 1);
      check_value("o_need_more_money", o_need_more_money, 0);
    end else begin
      waited = 0;
      while (!o_need_more_money && (waited < 8)) begin
        @(negedge i_clk);
        waited++;
      end
      if (!o_need_more_money) begin
        $display("product %0d was never accepted for payment", t_code[idx]);
        errors++;
      end
      for (int k = 0; k < t_count[idx]; k++) begin
        i_money = t_notes[idx][k];
        @(negedge i_clk);
        i_money = '0;
        @(negedge i_clk);
        if (is_denom(t_notes[idx][k])) sum += t_notes[idx][k];
        check_value("o_need_more_money", o_need_more_money, sum < price);
      end
      // Payout until the strobe
      waited = 0;
      while (!done && (waited < 40)) begin
        @(negedge i_clk);
        waited++;
        if (o_change != 0) begin
          check_value("o_change is a denomination", is_denom(o_change), 1);
          check_value("o_change not above previous note", o_change <= last, 1);
          last     = o_change;
          paid_out += o_change;
        end
        done = o_strobe;
      end
      if (!done) begin
        $display("no o_strobe after paying for product %0d", t_code[idx]);
        errors++;
      end else begin
        check_value("o_no_change", o_no_change, t_nc[idx]);
        check_value("o_change_total", o_change_total, t_total[idx]);
        check_value("o_product", o_product, t_code[idx]);
        check_value("o_change with o_strobe", o_change != 0,
                    (t_total[idx] != 0) && (t_nc[idx] == 0));
        if (t_nc[idx] != 0) begin
          check_value("payout short of o_change_total", paid_out < t_total[idx], 1);
        end else begin
          check_value("payout sum", paid_out, t_total[idx]);
        end
      end
    end
  endtask

  task automatic check_sold_out();
    int waited;
    waited = 0;
    while (!o_empty && (waited < 10)) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_empty) begin
      $display("o_empty did not rise after every product was sold");
      errors++;
    end
    repeat (2) begin
      @(negedge i_clk);
      i_buy     = 1'b1;
      i_product = 4'd1;
      @(negedge i_clk);
      i_buy = 1'b0;
      @(negedge i_clk);
      check_value("o_empty", o_empty, 1);
      check_value("o_busy", o_busy, 0);
    end
  endtask

  initial begin
    i_rst_n   = 1'b0;
    i_buy     = 1'b0;
    i_product = '0;
    i_money   = '0;
    load_lines();
    if (num_lines == 0) begin
      $display("no transactions were read from testbench/vm_input.txt");
      errors++;
    end else begin
      loaded = 1'b1;
      repeat (5) @(negedge i_clk);
      i_rst_n = 1'b1;
      @(negedge i_clk);
      check_value("o_busy", o_busy, 0);
      check_value("o_strobe", o_strobe, 0);
      check_value("o_no_change", o_no_change, 0);
      check_value("o_empty", o_empty, 0);
      check_value("o_change", o_change, 0);
      for (int n = 0; n < num_lines; n++) begin
        run_line(n);
        repeat ($unsigned($random(seed)) % 4) @(negedge i_clk);   // Idle gap
      end
      check_sold_out();
    end
    finish_run();
  end

  // Watchdog allows about 60 cycles per transaction
  initial begin
    wait (loaded);
    repeat (num_lines * 60) @(posedge i_clk);
    $display("timeout: the run did not finish within %0d clock cycles", num_lines * 60);
    errors++;
    finish_run();
  end

endmodule

/* testbench/vm_input.txt */
# code sold_out note_count note0 note1 note2 note3 change_total no_change
# sold_out 1 means the code is refused and the next line presents another code
6  0 3 100 50 25 0      0 0
1  0 1 500 0 0 0      400 0
7  0 3 50 25 10 0       5 0
10 0 1 200 0 0 0      150 0
2  0 3 100 30 100 0    50 0
3  0 2 100 25 0 0       5 1
1  0 2 50 50 0 0        0 0
1  1 0 0 0 0 0          0 0
4  0 1 500 0 0 0      300 0
5  0 3 100 50 50 0     20 0
8  0 2 200 10 0 0       0 0
9  0 3 100 25 5 0       0 0
10 0 1 2000 0 0 0    1950 0
10 1 0 0 0 0 0          0 0
2  0 3 100 25 25 0      0 0
6  0 1 200 0 0 0       25 0
7  0 1 100 0 0 0       20 1
3  0 4 50 50 10 10      0 0
4  0 1 500 0 0 0      300 0
5  0 1 200 0 0 0       20 0
8  0 3 100 100 10 0     0 0
9  0 3 100 25 5 0       0 0

/* all.f */
verilog/vm_pkg.sv
verilog/product_store.sv
verilog/change_picker.sv
verilog/cash_box.sv
verilog/vm_controller.sv
verilog/vending_machine.sv
testbench/tb_vending_machine.sv
